// File: Bender.yml
package:
  name: memsystem

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/memPkg.sv
      - rtl/cacheArray.sv
      - rtl/instrCache.sv
      - rtl/dataCache.sv
      - rtl/busArbiter.sv
      - rtl/busMemory.sv
      - rtl/memSystem.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/memSystemTb.sv

// File: rtl/busArbiter.sv
`timescale 1ns/100ps

module busArbiter (
  input  logic           clk,
  input  logic           arstN,
  input  memPkg::busReqT fetchBusReq,
  input  logic           fetchBusReqValid,
  output logic           fetchBusReqReady,
  input  memPkg::busReqT dataBusReq,
  input  logic           dataBusReqValid,
  output logic           dataBusReqReady,
  output memPkg::busRspT fetchBusRsp,
  output logic           fetchBusRspValid,
  output memPkg::busRspT dataBusRsp,
  output logic           dataBusRspValid,
  output memPkg::busReqT memReq,
  output logic           memReqValid,
  input  logic           memReqReady,
  input  memPkg::busRspT memRsp,
  input  logic           memRspValid
);

  logic grantData;
  // Owner of the transaction in the memory, 1 means data port
  logic ownerData;

  // Fixed priority, data port wins
  assign grantData   = dataBusReqValid;
  assign memReq      = grantData ? dataBusReq : fetchBusReq;
  assign memReqValid = dataBusReqValid || fetchBusReqValid;

  // Memory ready goes only to the granted side
  assign dataBusReqReady  = memReqReady;
  assign fetchBusReqReady = memReqReady && !grantData;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ownerData <= 1'b0;
    end else if (memReqValid && memReqReady) begin
      ownerData <= grantData;
    end
  end

  // Data fans out to both, valid only to the owner
  assign fetchBusRsp      = memRsp;
  assign dataBusRsp       = memRsp;
  assign fetchBusRspValid = memRspValid && !ownerData;
  assign dataBusRspValid  = memRspValid && ownerData;

endmodule

// File: rtl/busMemory.sv
`timescale 1ns/100ps
`include "memSettings.svh"

module busMemory (
  input  logic           clk,
  input  logic           arstN,
  input  memPkg::busReqT req,
  input  logic           reqValid,
  output logic           reqReady,
  output memPkg::busRspT rsp,
  output logic           rspValid
);

  localparam int AddrBits = $clog2(`MEM_WORDS);
  localparam int CntBits  = $clog2(`MEM_WAIT + 1);

  // Simulated memory powers up as zeros
  logic [31:0]         mem [`MEM_WORDS] = '{default: '0};
  memPkg::busReqT      curReq;
  logic                busy;
  logic [CntBits-1:0]  waitCnt;
  logic                fire;
  logic [AddrBits-1:0] wordIdx;

  assign reqReady = !busy;

  // Last wait cycle, response registered for the next one
  assign fire = busy && (waitCnt == CntBits'(1));

  // Word address wraps at the memory size
  assign wordIdx = curReq.addr[AddrBits+1:2];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      busy     <= 1'b0;
      waitCnt  <= '0;
      rspValid <= 1'b0;
    end else begin
      rspValid <= fire;
      if (!busy && reqValid) begin
        busy    <= 1'b1;
        waitCnt <= CntBits'(`MEM_WAIT - 1);
      end else if (fire) begin
        busy <= 1'b0;
      end else if (busy) begin
        waitCnt <= waitCnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reqValid && reqReady) begin
      curReq <= req;
    end
    if (fire) begin
      rsp.readData <= mem[wordIdx];
      if (curReq.write) begin
        for (int b = 0; b < 4; b++) begin
          if (curReq.byteMask[b]) begin
            mem[wordIdx][8*b +: 8] <= curReq.writeData[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

// File: rtl/cacheArray.sv
`timescale 1ns/100ps
`include "memSettings.svh"

module cacheArray (
  input  logic              clk,
  input  logic              arstN,
  input  logic              invalidate,
  input  logic [3:0]        index,
  input  logic [23:0]       tag,
  output memPkg::cacheLineT lookupLine,
  output logic              hit,
  input  logic              writeEn,
  input  memPkg::cacheLineT writeLine
);

  // Valid bits are flops so they can be flash cleared
  logic [`CACHE_SETS-1:0] validBits;
  // Tags and data sit in plain storage
  logic [23:0] tagMem [`CACHE_SETS];
  logic [`LINE_WORDS-1:0][31:0] dataMem [`CACHE_SETS];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validBits <= '0;
    end else if (invalidate) begin
      // Whole array dropped at once
      validBits <= '0;
    end else if (writeEn) begin
      validBits[index] <= writeLine.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (writeEn) begin
      tagMem[index]  <= writeLine.tag;
      dataMem[index] <= writeLine.data;
    end
  end

  // Combinational lookup by set index
  assign lookupLine.valid = validBits[index];
  assign lookupLine.tag   = tagMem[index];
  assign lookupLine.data  = dataMem[index];

  assign hit = lookupLine.valid && (lookupLine.tag == tag);

endmodule

// File: rtl/dataCache.sv
`timescale 1ns/100ps
`include "memSettings.svh"

module dataCache (
  input  logic            clk,
  input  logic            arstN,
  input  logic            invalidate,
  input  memPkg::dataReqT req,
  input  logic            reqValid,
  output logic            reqReady,
  output memPkg::cpuRspT  rsp,
  output logic            rspValid,
  output memPkg::busReqT  busReq,
  output logic            busReqValid,
  input  logic            busReqReady,
  input  memPkg::busRspT  busRsp,
  input  logic            busRspValid
);

  localparam logic [1:0] lastWord = 2'(`LINE_WORDS - 1);

  // Store waits for its bus write
  typedef enum logic [1:0] {Idle, Fill, Respond, Store} stateT;

  stateT                        state;
  memPkg::dataReqT              curReq;
  logic [1:0]                   wordCnt;
  logic                         waitRsp;
  logic [`LINE_WORDS-1:0][31:0] fillBuf;
  logic [31:0]                  lookupAddr;
  memPkg::cacheLineT            lookupLine;
  memPkg::cacheLineT            fillLine;
  memPkg::cacheLineT            storeLine;
  logic                         hit;
  logic                         accept;
  logic                         storeHit;

  assign reqReady = (state == Idle);
  assign accept   = reqValid && reqReady;
  // Write-through, line only touched when present
  assign storeHit = accept && req.write && hit;

  assign lookupAddr = (state == Idle) ? req.addr : curReq.addr;

  assign fillLine.valid = 1'b1;
  assign fillLine.tag   = curReq.addr[31:8];
  assign fillLine.data  = fillBuf;

  // Merge the enabled store bytes into the hit line
  always_comb begin
    storeLine = lookupLine;
    for (int b = 0; b < 4; b++) begin
      if (req.byteMask[b]) begin
        storeLine.data[req.addr[3:2]][8*b +: 8] = req.writeData[8*b +: 8];
      end
    end
  end

  cacheArray array (
    .clk        (clk),
    .arstN      (arstN),
    .invalidate (invalidate && (state == Idle)),
    .index      (lookupAddr[7:4]),
    .tag        (lookupAddr[31:8]),
    .lookupLine (lookupLine),
    .hit        (hit),
    .writeEn    (storeHit || (state == Respond)),
    .writeLine  ((state == Respond) ? fillLine : storeLine)
  );

  // Fill reads walk the line, a store passes through as is
  always_comb begin
    busReqValid = ((state == Fill) || (state == Store)) && !waitRsp;
    if (state == Store) begin
      busReq = '{addr: curReq.addr, write: 1'b1, writeData: curReq.writeData,
                 byteMask: curReq.byteMask};
    end else begin
      busReq = '{addr: {curReq.addr[31:4], wordCnt, 2'b00}, write: 1'b0,
                 writeData: '0, byteMask: 4'hF};
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state    <= Idle;
      wordCnt  <= '0;
      waitRsp  <= 1'b0;
      rspValid <= 1'b0;
    end else begin
      rspValid <= 1'b0;
      // One bus transaction outstanding at most
      if (busReqValid && busReqReady) begin
        waitRsp <= 1'b1;
      end else if (busRspValid) begin
        waitRsp <= 1'b0;
      end
      case (state)
        Idle: begin
          if (accept) begin
            if (req.write) begin
              state <= Store;
            end else if (hit) begin
              rspValid <= 1'b1;
            end else begin
              state   <= Fill;
              wordCnt <= '0;
            end
          end
        end
        Fill: begin
          if (busRspValid) begin
            wordCnt <= wordCnt + 2'd1;
            if (wordCnt == lastWord) begin
              state <= Respond;
            end
          end
        end
        Respond: begin
          rspValid <= 1'b1;
          state    <= Idle;
        end
        Store: begin
          // Write acknowledged, answer the core
          if (busRspValid) begin
            rspValid <= 1'b1;
            state    <= Idle;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      curReq <= req;
    end
    if ((state == Fill) && busRspValid) begin
      fillBuf[wordCnt] <= busRsp.readData;
    end
    // Store answers keep the last read data
    if (accept && !req.write && hit) begin
      rsp.readData <= lookupLine.data[req.addr[3:2]];
    end else if (state == Respond) begin
      rsp.readData <= fillBuf[curReq.addr[3:2]];
    end
  end

endmodule

// File: rtl/instrCache.sv
`timescale 1ns/100ps
`include "memSettings.svh"

module instrCache (
  input  logic             clk,
  input  logic             arstN,
  input  logic             invalidate,
  input  memPkg::fetchReqT req,
  input  logic             reqValid,
  output logic             reqReady,
  output memPkg::cpuRspT   rsp,
  output logic             rspValid,
  output memPkg::busReqT   busReq,
  output logic             busReqValid,
  input  logic             busReqReady,
  input  memPkg::busRspT   busRsp,
  input  logic             busRspValid
);

  localparam logic [1:0] lastWord = 2'(`LINE_WORDS - 1);

  typedef enum logic [1:0] {Idle, Fill, Respond} stateT;

  stateT                        state;
  memPkg::fetchReqT             curReq;
  logic [1:0]                   wordCnt;
  logic                         waitRsp;
  logic [`LINE_WORDS-1:0][31:0] fillBuf;
  logic [31:0]                  lookupAddr;
  memPkg::cacheLineT            lookupLine;
  memPkg::cacheLineT            fillLine;
  logic                         hit;
  logic                         accept;

  // Only one request in flight
  assign reqReady = (state == Idle);
  assign accept   = reqValid && reqReady;

  // Incoming address while idle, otherwise the latched miss
  assign lookupAddr = (state == Idle) ? req.addr : curReq.addr;

  // Completed line from the fill buffer
  assign fillLine.valid = 1'b1;
  assign fillLine.tag   = curReq.addr[31:8];
  assign fillLine.data  = fillBuf;

  cacheArray array (
    .clk        (clk),
    .arstN      (arstN),
    .invalidate (invalidate && (state == Idle)),
    .index      (lookupAddr[7:4]),
    .tag        (lookupAddr[31:8]),
    .lookupLine (lookupLine),
    .hit        (hit),
    .writeEn    (state == Respond),
    .writeLine  (fillLine)
  );

  // Line fill reads, word 0 first, one at a time
  assign busReqValid      = (state == Fill) && !waitRsp;
  assign busReq.addr      = {curReq.addr[31:4], wordCnt, 2'b00};
  assign busReq.write     = 1'b0;
  assign busReq.writeData = '0;
  assign busReq.byteMask  = 4'hF;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state    <= Idle;
      wordCnt  <= '0;
      waitRsp  <= 1'b0;
      rspValid <= 1'b0;
    end else begin
      rspValid <= 1'b0;
      case (state)
        Idle: begin
          if (accept) begin
            if (hit) begin
              rspValid <= 1'b1;
            end else begin
              state   <= Fill;
              wordCnt <= '0;
            end
          end
        end
        Fill: begin
          if (busReqValid && busReqReady) begin
            waitRsp <= 1'b1;
          end
          if (busRspValid) begin
            waitRsp <= 1'b0;
            wordCnt <= wordCnt + 2'd1;
            // Last word in, line goes to the array next cycle
            if (wordCnt == lastWord) begin
              state <= Respond;
            end
          end
        end
        Respond: begin
          rspValid <= 1'b1;
          state    <= Idle;
        end
        default: state <= Idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      curReq <= req;
    end
    if ((state == Fill) && busRspValid) begin
      fillBuf[wordCnt] <= busRsp.readData;
    end
    // Hit word from the array, miss word from the fill buffer
    if (accept && hit) begin
      rsp.readData <= lookupLine.data[req.addr[3:2]];
    end else if (state == Respond) begin
      rsp.readData <= fillBuf[curReq.addr[3:2]];
    end
  end

endmodule

// File: rtl/memPkg.sv
`include "memSettings.svh"

package memPkg;

  // Fetch request from the core, byte address
  typedef struct packed {
    logic [31:0] addr;
  } fetchReqT;

  // Load or store request from the core
  typedef struct packed {
    logic [31:0] addr;
    logic        write;
    logic [31:0] writeData;
    // One enable per byte lane, lane 0 is bits 7..0
    logic [3:0]  byteMask;
  } dataReqT;

  // Read data back to the core
  typedef struct packed {
    logic [31:0] readData;
  } cpuRspT;

  // Single word transaction on the shared bus
  typedef struct packed {
    logic [31:0] addr;
    logic        write;
    logic [31:0] writeData;
    logic [3:0]  byteMask;
  } busReqT;

  // Bus response, data only meaningful for reads
  typedef struct packed {
    logic [31:0] readData;
  } busRspT;

  // One cache line
  // Tag is address bits 31..8
  typedef struct packed {
    logic                         valid;
    logic [23:0]                  tag;
    logic [`LINE_WORDS-1:0][31:0] data;
  } cacheLineT;

endpackage

// File: rtl/memSettings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Geometry and timing of the memory side

// Words per cache line
`define LINE_WORDS 4

// Sets in each direct-mapped cache
`define CACHE_SETS 16

// Backing memory size in 32-bit words
`define MEM_WORDS 1024

// Cycles from bus accept to bus response
`define MEM_WAIT 2

`endif

// File: rtl/memSystem.sv
`timescale 1ns/100ps

module memSystem (
  input  logic             clk,
  input  logic             arstN,
  input  memPkg::fetchReqT fetchReq,
  input  logic             fetchReqValid,
  output logic             fetchReqReady,
  output memPkg::cpuRspT   fetchRsp,
  output logic             fetchRspValid,
  input  memPkg::dataReqT  dataReq,
  input  logic             dataReqValid,
  output logic             dataReqReady,
  output memPkg::cpuRspT   dataRsp,
  output logic             dataRspValid,
  input  logic             invalidate
);

  // Instruction cache to arbiter
  memPkg::busReqT fetchBusReq;
  logic           fetchBusReqValid;
  logic           fetchBusReqReady;
  memPkg::busRspT fetchBusRsp;
  logic           fetchBusRspValid;

  // Data cache to arbiter
  memPkg::busReqT dataBusReq;
  logic           dataBusReqValid;
  logic           dataBusReqReady;
  memPkg::busRspT dataBusRsp;
  logic           dataBusRspValid;

  // Arbiter to memory
  memPkg::busReqT memReq;
  logic           memReqValid;
  logic           memReqReady;
  memPkg::busRspT memRsp;
  logic           memRspValid;

  // Same invalidate pulse reaches both caches
  instrCache iCache (
    .clk         (clk),
    .arstN       (arstN),
    .invalidate  (invalidate),
    .req         (fetchReq),
    .reqValid    (fetchReqValid),
    .reqReady    (fetchReqReady),
    .rsp         (fetchRsp),
    .rspValid    (fetchRspValid),
    .busReq      (fetchBusReq),
    .busReqValid (fetchBusReqValid),
    .busReqReady (fetchBusReqReady),
    .busRsp      (fetchBusRsp),
    .busRspValid (fetchBusRspValid)
  );

  dataCache dCache (
    .clk         (clk),
    .arstN       (arstN),
    .invalidate  (invalidate),
    .req         (dataReq),
    .reqValid    (dataReqValid),
    .reqReady    (dataReqReady),
    .rsp         (dataRsp),
    .rspValid    (dataRspValid),
    .busReq      (dataBusReq),
    .busReqValid (dataBusReqValid),
    .busReqReady (dataBusReqReady),
    .busRsp      (dataBusRsp),
    .busRspValid (dataBusRspValid)
  );

  busArbiter arbiter (
    .clk              (clk),
    .arstN            (arstN),
    .fetchBusReq      (fetchBusReq),
    .fetchBusReqValid (fetchBusReqValid),
    .fetchBusReqReady (fetchBusReqReady),
    .dataBusReq       (dataBusReq),
    .dataBusReqValid  (dataBusReqValid),
    .dataBusReqReady  (dataBusReqReady),
    .fetchBusRsp      (fetchBusRsp),
    .fetchBusRspValid (fetchBusRspValid),
    .dataBusRsp       (dataBusRsp),
    .dataBusRspValid  (dataBusRspValid),
    .memReq           (memReq),
    .memReqValid      (memReqValid),
    .memReqReady      (memReqReady),
    .memRsp           (memRsp),
    .memRspValid      (memRspValid)
  );

  busMemory memory (
    .clk      (clk),
    .arstN    (arstN),
    .req      (memReq),
    .reqValid (memReqValid),
    .reqReady (memReqReady),
    .rsp      (memRsp),
    .rspValid (memRspValid)
  );

endmodule

// File: testbench/memSystemTb.sv
`timescale 1ns/100ps
`include "memSettings.svh"

module memSystemTb;

  // Table operation codes
  localparam int OpFetch    = 0;
  localparam int OpLoad     = 1;
  localparam int OpStore    = 2;
  localparam int OpInval    = 3;
  // Fetch and load issued in the same cycle
  localparam int OpPair     = 4;
  // Hit expected, answer due one cycle after acceptance
  localparam int OpFetchHit = 5;
  localparam int OpLoadHit  = 6;

  logic             clk;
  logic             arstN;
  memPkg::fetchReqT fetchReq;
  logic             fetchReqValid;
  logic             fetchReqReady;
  memPkg::cpuRspT   fetchRsp;
  logic             fetchRspValid;
  memPkg::dataReqT  dataReq;
  logic             dataReqValid;
  logic             dataReqReady;
  memPkg::cpuRspT   dataRsp;
  logic             dataRspValid;
  logic             invalidate;

  // Stimulus table, one column per queue
  int          opTab[$];
  logic [31:0] addrTab[$];
  logic [31:0] addr2Tab[$];
  logic [31:0] dataTab[$];
  logic [3:0]  maskTab[$];
  string       nameTab[$];

  // Reference copy of the backing memory
  logic [31:0] modelMem [`MEM_WORDS];
  int          errors;
  int          checks;
  int          cycleCnt;
  int          cycleLimit;

  memSystem uut (
    .clk           (clk),
    .arstN         (arstN),
    .fetchReq      (fetchReq),
    .fetchReqValid (fetchReqValid),
    .fetchReqReady (fetchReqReady),
    .fetchRsp      (fetchRsp),
    .fetchRspValid (fetchRspValid),
    .dataReq       (dataReq),
    .dataReqValid  (dataReqValid),
    .dataReqReady  (dataReqReady),
    .dataRsp       (dataRsp),
    .dataRspValid  (dataRspValid),
    .invalidate    (invalidate)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Word slot in the model, wraps like the memory
  function automatic int modelIndex(input logic [31:0] addr);
    return int'((addr >> 2) % `MEM_WORDS);
  endfunction

  task automatic addEntry(input int op, input logic [31:0] addr, input logic [31:0] addr2,
                          input logic [31:0] data, input logic [3:0] mask, input string name);
    opTab.push_back(op);
    addrTab.push_back(addr);
    addr2Tab.push_back(addr2);
    dataTab.push_back(data);
    maskTab.push_back(mask);
    nameTab.push_back(name);
  endtask

  // Enabled bytes only
  task automatic applyStoreToModel(input logic [31:0] addr, input logic [31:0] data,
                                   input logic [3:0] mask);
    int idx;
    idx = modelIndex(addr);
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        modelMem[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    errors++;
    $display("Fail %s: expected %08h, actual %08h", name, expected, actual);
  endtask

  // Request held until ready, then wait for the answer
  task automatic fetchWord(input logic [31:0] addr, input logic expectHit,
                           input string name);
    logic [31:0] expected;
    int          waited;
    expected = modelMem[modelIndex(addr)];
    @(posedge clk);
    fetchReq.addr <= addr;
    fetchReqValid <= 1'b1;
    @(posedge clk);
    while (!fetchReqReady) @(posedge clk);
    fetchReqValid <= 1'b0;
    @(posedge clk);
    waited = 1;
    while (!fetchRspValid) begin
      @(posedge clk);
      waited++;
    end
    checks++;
    if (fetchRsp.readData !== expected) begin
      reportMismatch(name, expected, fetchRsp.readData);
    end
    // Hit answers in the cycle after acceptance
    if (expectHit) begin
      checks++;
      if (waited != 1) begin
        reportMismatch({name, " latency"}, 32'd1, 32'(waited));
      end
    end
  endtask

  // Load when write is low, store otherwise
  task automatic accessData(input logic [31:0] addr, input logic write,
                            input logic [31:0] data, input logic [3:0] mask,
                            input logic expectHit, input string name);
    logic [31:0] expected;
    int          waited;
    if (write) begin
      applyStoreToModel(addr, data, mask);
    end
    expected = modelMem[modelIndex(addr)];
    @(posedge clk);
    dataReq.addr      <= addr;
    dataReq.write     <= write;
    dataReq.writeData <= data;
    dataReq.byteMask  <= mask;
    dataReqValid      <= 1'b1;
    @(posedge clk);
    while (!dataReqReady) @(posedge clk);
    dataReqValid <= 1'b0;
    @(posedge clk);
    waited = 1;
    while (!dataRspValid) begin
      @(posedge clk);
      waited++;
    end
    // Store answer carries no data
    if (!write) begin
      checks++;
      if (dataRsp.readData !== expected) begin
        reportMismatch(name, expected, dataRsp.readData);
      end
    end
    if (expectHit) begin
      checks++;
      if (waited != 1) begin
        reportMismatch({name, " latency"}, 32'd1, 32'(waited));
      end
    end
  endtask

  // One cycle pulse, both caches idle between entries
  task automatic pulseInvalidate();
    @(posedge clk);
    invalidate <= 1'b1;
    @(posedge clk);
    invalidate <= 1'b0;
  endtask

  task automatic buildTable();
    // Full store, then miss and hit
    addEntry(OpStore, 32'h100, '0, 32'hA5A55A5A, 4'hF, "store word A");
    addEntry(OpLoad,  32'h100, '0, '0, 4'h0, "load A miss");
    addEntry(OpLoadHit, 32'h100, '0, '0, 4'h0, "load A hit");
    // Partial stores, one hit and one miss
    addEntry(OpStore, 32'h100, '0, 32'h11223344, 4'b0101, "partial store A");
    addEntry(OpLoadHit, 32'h100, '0, '0, 4'h0, "load A merged");
    addEntry(OpStore, 32'h204, '0, 32'hCAFEF00D, 4'b1100, "partial store B");
    addEntry(OpLoad,  32'h204, '0, '0, 4'h0, "load B merged");
    // Code written through the data port
    addEntry(OpStore, 32'h308, '0, 32'h13579BDF, 4'hF, "store code word");
    addEntry(OpFetch, 32'h308, '0, '0, 4'h0, "fetch code miss");
    addEntry(OpFetchHit, 32'h308, '0, '0, 4'h0, "fetch code hit");
    addEntry(OpFetchHit, 32'h30C, '0, '0, 4'h0, "fetch same line word 3");
    addEntry(OpFetchHit, 32'h300, '0, '0, 4'h0, "fetch same line word 0");
    // Random words in four sets, then both ports at once
    addEntry(OpStore, 32'h400, '0, $urandom(), 4'hF, "random store 0");
    addEntry(OpStore, 32'h414, '0, $urandom(), 4'hF, "random store 1");
    addEntry(OpStore, 32'h528, '0, $urandom(), 4'hF, "random store 2");
    addEntry(OpStore, 32'h63C, '0, $urandom(), 4'hF, "random store 3");
    addEntry(OpPair,  32'h400, 32'h528, '0, 4'h0, "pair 1");
    addEntry(OpPair,  32'h414, 32'h63C, '0, 4'h0, "pair 2");
    addEntry(OpPair,  32'h528, 32'h400, '0, 4'h0, "pair 3");
    addEntry(OpPair,  32'h63C, 32'h414, '0, 4'h0, "pair 4");
    // Stale fetch line cleared by invalidate
    addEntry(OpFetch, 32'h700, '0, '0, 4'h0, "fetch before overwrite");
    addEntry(OpStore, 32'h700, '0, $urandom(), 4'hF, "overwrite fetched word");
    addEntry(OpInval, '0, '0, '0, 4'h0, "invalidate");
    addEntry(OpFetch, 32'h700, '0, '0, 4'h0, "fetch after invalidate");
    addEntry(OpLoad,  32'h100, '0, '0, 4'h0, "load A after invalidate");
  endtask

  // Watchdog sized from the table length
  initial begin
    cycleCnt = 0;
    @(posedge arstN);
    while (cycleCnt < cycleLimit) begin
      @(posedge clk);
      cycleCnt++;
    end
    $display("Timeout after %0d cycles, a request was never answered", cycleCnt);
    $display("Errors found");
    $finish;
  end

  initial begin
    void'($urandom(14108));
    arstN         = 1'b0;
    fetchReq      = '0;
    fetchReqValid = 1'b0;
    dataReq       = '0;
    dataReqValid  = 1'b0;
    invalidate    = 1'b0;
    errors        = 0;
    checks        = 0;
    // Memory powers up as zeros
    for (int w = 0; w < `MEM_WORDS; w++) begin
      modelMem[w] = '0;
    end
    buildTable();
    cycleLimit = opTab.size() * (2 * `LINE_WORDS * (`MEM_WAIT + 2) + 10);
    repeat (5) @(posedge clk);
    arstN <= 1'b1;
    @(posedge clk);
    // Idle state straight out of reset
    checks += 4;
    if (fetchReqReady !== 1'b1) begin
      reportMismatch("reset fetchReqReady", 32'd1, 32'(fetchReqReady));
    end
    if (dataReqReady !== 1'b1) begin
      reportMismatch("reset dataReqReady", 32'd1, 32'(dataReqReady));
    end
    if (fetchRspValid !== 1'b0) begin
      reportMismatch("reset fetchRspValid", 32'd0, 32'(fetchRspValid));
    end
    if (dataRspValid !== 1'b0) begin
      reportMismatch("reset dataRspValid", 32'd0, 32'(dataRspValid));
    end
    for (int e = 0; e < opTab.size(); e++) begin
      case (opTab[e])
        OpFetch:    fetchWord(addrTab[e], 1'b0, nameTab[e]);
        OpFetchHit: fetchWord(addrTab[e], 1'b1, nameTab[e]);
        OpLoad:     accessData(addrTab[e], 1'b0, '0, 4'h0, 1'b0, nameTab[e]);
        OpLoadHit:  accessData(addrTab[e], 1'b0, '0, 4'h0, 1'b1, nameTab[e]);
        OpStore:    accessData(addrTab[e], 1'b1, dataTab[e], maskTab[e], 1'b0, nameTab[e]);
        OpInval:    pulseInvalidate();
        OpPair: begin
          fork
            fetchWord(addrTab[e], 1'b0, {nameTab[e], " fetch"});
            accessData(addr2Tab[e], 1'b0, '0, 4'h0, 1'b0, {nameTab[e], " load"});
          join
        end
        default: begin
          errors++;
          $display("Unknown operation in table entry %0d", e);
        end
      endcase
    end
    @(posedge clk);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+rtl
rtl/memPkg.sv
rtl/cacheArray.sv
rtl/instrCache.sv
rtl/dataCache.sv
rtl/busArbiter.sv
rtl/busMemory.sv
rtl/memSystem.sv
testbench/memSystemTb.sv
